//--- axi4_wr_mem_slave.sv
// AXI4 write target over a word memory with byte strobes
// Incrementing full-width bursts only, one burst at a time
// A burst reaching past MEM_WORDS writes nothing and answers SLVERR
// Side read port takes a word index and returns data one cycle later

`default_nettype none

module axi4_wr_mem_slave (
  input  logic                                clk,
  input  logic                                rst_n,
  input  axi_wr_pkg::axi_aw_t                 slv_aw,
  input  logic                                slv_awvalid,
  output logic                                slv_awready,
  input  axi_wr_pkg::axi_w_t                  slv_w,
  input  logic                                slv_wvalid,
  output logic                                slv_wready,
  output axi_wr_pkg::axi_b_t                  slv_b,
  output logic                                slv_bvalid,
  input  logic                                slv_bready,
  input  logic [axi_wr_pkg::MEM_IDX_W-1:0]    mem_rd_addr,
  output logic [axi_wr_pkg::DATA_W-1:0]       mem_rd_data
);

  logic [axi_wr_pkg::DATA_W-1:0]  mem [axi_wr_pkg::MEM_WORDS];

  logic [axi_wr_pkg::ID_W-1:0]       b_id;
  logic                              bad;
  logic [axi_wr_pkg::MEM_IDX_W-1:0]  wr_idx;
  // Word index of the final beat, one bit wider to catch overflow
  logic [axi_wr_pkg::ADDR_W-2:0]     last_word;
  logic                              beat_we;

  assign last_word = {1'b0, slv_aw.addr[axi_wr_pkg::ADDR_W-1:2]} + {7'b0, slv_aw.len};
  assign beat_we   = slv_wready && slv_wvalid && !bad;
  assign slv_b     = '{id: b_id, resp: (bad ? axi_wr_pkg::RESP_SLVERR : axi_wr_pkg::RESP_OKAY)};

  // --------------------
  // Handshake sequencing
  // --------------------
  // AW, then W beats, then B; ready/valid flags double as the state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slv_awready <= 1'b0;
      slv_wready  <= 1'b0;
      slv_bvalid  <= 1'b0;
      bad         <= 1'b0;
      b_id        <= '0;
      wr_idx      <= '0;
    end else begin
      // Idle, open the address channel
      if (!slv_awready && !slv_wready && !slv_bvalid) begin
        slv_awready <= 1'b1;
      end
      if (slv_awready && slv_awvalid) begin
        slv_awready <= 1'b0;
        slv_wready  <= 1'b1;
        b_id        <= slv_aw.id;
        wr_idx      <= slv_aw.addr[axi_wr_pkg::MEM_IDX_W+1:2];
        bad         <= (last_word >= axi_wr_pkg::MEM_WORDS);
      end
      if (slv_wready && slv_wvalid) begin
        wr_idx <= wr_idx + 1'b1;
        if (slv_w.last) begin
          slv_wready <= 1'b0;
          slv_bvalid <= 1'b1;
        end
      end
      if (slv_bvalid && slv_bready) begin
        slv_bvalid <= 1'b0;
      end
    end
  end

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge clk) begin
    if (beat_we) begin
      for (int b = 0; b < axi_wr_pkg::STRB_W; b++) begin
        if (slv_w.strb[b]) begin
          mem[wr_idx][8*b +: 8] <= slv_w.data[8*b +: 8];
        end
      end
    end
  end

  // Registered read for checking memory contents
  always_ff @(posedge clk) begin
    mem_rd_data <= mem[mem_rd_addr];
  end

endmodule

`default_nettype wire

//--- axi4_wr_subsys.sv
// Four-master AXI4 write subsystem: config block, arbiter and memory target
// Only the write channels exist; one burst is in flight at a time

`default_nettype none

module axi4_wr_subsys (
  input  logic                                            clk,
  input  logic                                            rst_n,

  // Masters
  input  axi_wr_pkg::axi_aw_t [axi_wr_pkg::NUM_MST-1:0]   mst_aw,
  input  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_awvalid,
  output logic [axi_wr_pkg::NUM_MST-1:0]                  mst_awready,
  input  axi_wr_pkg::axi_w_t  [axi_wr_pkg::NUM_MST-1:0]   mst_w,
  input  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_wvalid,
  output logic [axi_wr_pkg::NUM_MST-1:0]                  mst_wready,
  output axi_wr_pkg::axi_b_t  [axi_wr_pkg::NUM_MST-1:0]   mst_b,
  output logic [axi_wr_pkg::NUM_MST-1:0]                  mst_bvalid,
  input  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_bready,

  // Config port
  input  logic                                            cfg_we,
  input  logic [axi_wr_pkg::CFG_ADDR_W-1:0]               cfg_addr,
  input  logic [axi_wr_pkg::CFG_DATA_W-1:0]               cfg_wdata,
  output logic [axi_wr_pkg::CFG_DATA_W-1:0]               cfg_rdata,

  // Memory read-back
  input  logic [axi_wr_pkg::MEM_IDX_W-1:0]                mem_rd_addr,
  output logic [axi_wr_pkg::DATA_W-1:0]                   mem_rd_data
);

  // --------------------
  // Internal links
  // --------------------
  axi_wr_pkg::axi_aw_t                slv_aw;
  logic                               slv_awvalid;
  logic                               slv_awready;
  axi_wr_pkg::axi_w_t                 slv_w;
  logic                               slv_wvalid;
  logic                               slv_wready;
  axi_wr_pkg::axi_b_t                 slv_b;
  logic                               slv_bvalid;
  logic                               slv_bready;
  logic [axi_wr_pkg::NUM_MST-1:0]     en_mask;
  logic                               gnt_stb;
  logic [axi_wr_pkg::MST_IDX_W-1:0]   gnt_idx;

  wr_arb_cfg u_wr_arb_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .gnt_stb   (gnt_stb),
    .gnt_idx   (gnt_idx),
    .en_mask   (en_mask)
  );

  axi4_write_arbiter u_axi4_write_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .en_mask     (en_mask),
    .mst_aw      (mst_aw),
    .mst_awvalid (mst_awvalid),
    .mst_awready (mst_awready),
    .mst_w       (mst_w),
    .mst_wvalid  (mst_wvalid),
    .mst_wready  (mst_wready),
    .mst_b       (mst_b),
    .mst_bvalid  (mst_bvalid),
    .mst_bready  (mst_bready),
    .slv_aw      (slv_aw),
    .slv_awvalid (slv_awvalid),
    .slv_awready (slv_awready),
    .slv_w       (slv_w),
    .slv_wvalid  (slv_wvalid),
    .slv_wready  (slv_wready),
    .slv_b       (slv_b),
    .slv_bvalid  (slv_bvalid),
    .slv_bready  (slv_bready),
    .gnt_stb     (gnt_stb),
    .gnt_idx     (gnt_idx)
  );

  axi4_wr_mem_slave u_axi4_wr_mem_slave (
    .clk         (clk),
    .rst_n       (rst_n),
    .slv_aw      (slv_aw),
    .slv_awvalid (slv_awvalid),
    .slv_awready (slv_awready),
    .slv_w       (slv_w),
    .slv_wvalid  (slv_wvalid),
    .slv_wready  (slv_wready),
    .slv_b       (slv_b),
    .slv_bvalid  (slv_bvalid),
    .slv_bready  (slv_bready),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data)
  );

endmodule

`default_nettype wire

//--- axi4_wr_subsys_chk.sv
// Concurrent protocol and arbitration checks, bound into the subsystem top
// Each failing assertion raises $error and bumps fail_cnt for the testbench
// Reset check starts once reset has been low for a full cycle

module axi4_wr_subsys_chk (
  input logic                                clk,
  input logic                                rst_n,
  input logic [axi_wr_pkg::NUM_MST-1:0]      en_mask,
  input logic [axi_wr_pkg::NUM_MST-1:0]      mst_awvalid,
  input logic [axi_wr_pkg::NUM_MST-1:0]      mst_awready,
  input logic [axi_wr_pkg::NUM_MST-1:0]      mst_wready,
  input logic [axi_wr_pkg::NUM_MST-1:0]      mst_bvalid,
  input axi_wr_pkg::axi_aw_t                 slv_aw,
  input logic                                slv_awvalid,
  input logic                                slv_awready,
  input axi_wr_pkg::axi_w_t                  slv_w,
  input logic                                slv_wvalid,
  input logic                                slv_wready,
  input logic                                slv_bvalid,
  input logic                                gnt_stb,
  input logic [axi_wr_pkg::MST_IDX_W-1:0]    gnt_idx
);

  // Owner of the most recent AW handshake
  int                              last_aw_mst;
  // Mask seen by the arbiter on the grant cycle
  logic [axi_wr_pkg::NUM_MST-1:0]  en_mask_d;
  int                              fail_cnt = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_aw_mst <= 0;
      en_mask_d   <= '1;
    end else begin
      en_mask_d <= en_mask;
      for (int i = 0; i < axi_wr_pkg::NUM_MST; i++) begin
        if (mst_awvalid[i] && mst_awready[i]) begin
          last_aw_mst <= i;
        end
      end
    end
  end

  // --------------------
  // Reset and grant rules
  // --------------------
  assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |->
      (mst_awready == '0 && mst_wready == '0 && mst_bvalid == '0 && !gnt_stb &&
       !slv_awvalid && !slv_wvalid && !slv_awready && !slv_wready && !slv_bvalid))
    else begin
      fail_cnt++;
      $error("Valid or ready output high during reset");
    end

  // Only the owner may see ready
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(mst_awready | mst_wready))
    else begin
      fail_cnt++;
      $error("Ready shown to more than one master");
    end

  assert property (@(posedge clk) disable iff (!rst_n) gnt_stb |-> en_mask_d[gnt_idx])
    else begin
      fail_cnt++;
      $error("Grant issued to a disabled master");
    end

  // --------------------
  // Channel stability and routing
  // --------------------
  assert property (@(posedge clk) disable iff (!rst_n)
      slv_awvalid && !slv_awready |=> slv_awvalid && $stable(slv_aw))
    else begin
      fail_cnt++;
      $error("AW dropped or changed before its handshake");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
      slv_wvalid && !slv_wready |=> slv_wvalid && $stable(slv_w))
    else begin
      fail_cnt++;
      $error("W dropped or changed before its handshake");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
      mst_bvalid != '0 |-> $onehot(mst_bvalid) && mst_bvalid[last_aw_mst])
    else begin
      fail_cnt++;
      $error("Write response routed to a master that did not issue the burst");
    end

endmodule

bind axi4_wr_subsys axi4_wr_subsys_chk u_axi4_wr_subsys_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .en_mask     (en_mask),
  .mst_awvalid (mst_awvalid),
  .mst_awready (mst_awready),
  .mst_wready  (mst_wready),
  .mst_bvalid  (mst_bvalid),
  .slv_aw      (slv_aw),
  .slv_awvalid (slv_awvalid),
  .slv_awready (slv_awready),
  .slv_w       (slv_w),
  .slv_wvalid  (slv_wvalid),
  .slv_wready  (slv_wready),
  .slv_bvalid  (slv_bvalid),
  .gnt_stb     (gnt_stb),
  .gnt_idx     (gnt_idx)
);

//--- axi4_write_arbiter.sv
// Round-robin AXI4 write arbiter, one burst in flight at a time
// Find state checks a single candidate per cycle at the rotating pointer
// Granted master owns AW, W and B until its B transfer completes
// Assumes the target is idle whenever the arbiter is back in find

`default_nettype none

module axi4_write_arbiter (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic [axi_wr_pkg::NUM_MST-1:0]                  en_mask,

  // Master side
  input  axi_wr_pkg::axi_aw_t [axi_wr_pkg::NUM_MST-1:0]   mst_aw,
  input  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_awvalid,
  output logic [axi_wr_pkg::NUM_MST-1:0]                  mst_awready,
  input  axi_wr_pkg::axi_w_t  [axi_wr_pkg::NUM_MST-1:0]   mst_w,
  input  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_wvalid,
  output logic [axi_wr_pkg::NUM_MST-1:0]                  mst_wready,
  output axi_wr_pkg::axi_b_t  [axi_wr_pkg::NUM_MST-1:0]   mst_b,
  output logic [axi_wr_pkg::NUM_MST-1:0]                  mst_bvalid,
  input  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_bready,

  // Slave side
  output axi_wr_pkg::axi_aw_t                             slv_aw,
  output logic                                            slv_awvalid,
  input  logic                                            slv_awready,
  output axi_wr_pkg::axi_w_t                              slv_w,
  output logic                                            slv_wvalid,
  input  logic                                            slv_wready,
  input  axi_wr_pkg::axi_b_t                              slv_b,
  input  logic                                            slv_bvalid,
  output logic                                            slv_bready,

  // Grant report to the config block
  output logic                                            gnt_stb,
  output logic [axi_wr_pkg::MST_IDX_W-1:0]                gnt_idx
);

  typedef enum logic [1:0] {
    ST_FIND = 2'd0,
    ST_DATA = 2'd1,
    ST_RESP = 2'd2
  } arb_state_t;

  arb_state_t                        state;
  logic [axi_wr_pkg::MST_IDX_W-1:0]  ptr;
  logic [axi_wr_pkg::MST_IDX_W-1:0]  sel;
  // AW of the current burst already taken by the target
  logic                              aw_done;

  assign gnt_idx = sel;

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_FIND;
      ptr     <= '0;
      sel     <= '0;
      aw_done <= 1'b0;
      gnt_stb <= 1'b0;
    end else begin
      gnt_stb <= 1'b0;
      case (state)
        ST_FIND: begin
          // Pointer walks every cycle, granted or not
          ptr <= ptr + 1'b1;
          if (en_mask[ptr] && mst_awvalid[ptr]) begin
            sel     <= ptr;
            aw_done <= 1'b0;
            gnt_stb <= 1'b1;
            state   <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (slv_awvalid && slv_awready) begin
            aw_done <= 1'b1;
          end
          // Burst body ends on the last W beat
          if (slv_wvalid && slv_wready && slv_w.last) begin
            state <= ST_RESP;
          end
        end
        ST_RESP: begin
          // Owner took its response, release the target
          if (slv_bvalid && slv_bready) begin
            state <= ST_FIND;
          end
        end
        default: state <= ST_FIND;
      endcase
    end
  end

  // --------------------
  // Channel multiplexer
  // --------------------
  always_comb begin
    slv_aw      = mst_aw[sel];
    slv_w       = mst_w[sel];
    slv_awvalid = 1'b0;
    slv_wvalid  = 1'b0;
    slv_bready  = 1'b0;
    mst_awready = '0;
    mst_wready  = '0;
    mst_bvalid  = '0;
    mst_b       = '0;
    case (state)
      ST_DATA: begin
        // Mask the owner's next AW once this burst's AW is taken
        if (!aw_done) begin
          slv_awvalid      = mst_awvalid[sel];
          mst_awready[sel] = slv_awready;
        end
        slv_wvalid      = mst_wvalid[sel];
        mst_wready[sel] = slv_wready;
      end
      ST_RESP: begin
        // Response goes back only to the burst owner
        slv_bready      = mst_bready[sel];
        mst_bvalid[sel] = slv_bvalid;
        mst_b[sel]      = slv_b;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- axi_wr_pkg.sv
// Shared widths, memory depth, AXI write channel beats and register map
// Bursts are full width and incrementing only, so size/burst/lock/cache/prot/qos are absent
// Memory covers byte addresses 0 to MEM_WORDS*4-1

package axi_wr_pkg;

  // --------------------
  // Bus geometry
  // --------------------
  localparam int NUM_MST   = 4;
  localparam int ID_W      = 3;
  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = 4;
  localparam int MST_IDX_W = 2;

  // Target memory, 1 KiB of 32-bit words
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = 8;

  // Write response codes
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // --------------------
  // Config register map
  // --------------------
  localparam int CFG_ADDR_W = 3;
  localparam int CFG_DATA_W = 16;
  localparam logic [CFG_ADDR_W-1:0] REG_EN_MASK  = 3'd0;
  // Grant counters of masters 0..3 sit at 1..4
  localparam logic [CFG_ADDR_W-1:0] REG_GNT_BASE = 3'd1;

  // --------------------
  // Channel beats
  // --------------------
  // Write address, 27 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } axi_aw_t;

  // Write data, 37 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  // Write response, 5 bits
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI4 write subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi4_wr_subsys -f sources.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

# Keep running after the first assertion so the testbench can report totals
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  exit 0
fi
exit 1

//--- sources.f
axi_wr_pkg.sv
axi4_write_arbiter.sv
wr_arb_cfg.sv
axi4_wr_mem_slave.sv
axi4_wr_subsys.sv
axi4_wr_subsys_chk.sv
tb_axi4_wr_subsys.sv

//--- tb_axi4_wr_subsys.sv
// Testbench for the four-master AXI4 write subsystem
// Masters hold valid and payload until ready; a model memory predicts read-back
// Only words the model has written are compared against the DUT memory

module tb_axi4_wr_subsys;

  localparam int ROUNDS = 3;

  logic                                            clk = 1'b0;
  logic                                            rst_n;
  axi_wr_pkg::axi_aw_t [axi_wr_pkg::NUM_MST-1:0]   mst_aw;
  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_awvalid;
  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_awready;
  axi_wr_pkg::axi_w_t  [axi_wr_pkg::NUM_MST-1:0]   mst_w;
  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_wvalid;
  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_wready;
  axi_wr_pkg::axi_b_t  [axi_wr_pkg::NUM_MST-1:0]   mst_b;
  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_bvalid;
  logic [axi_wr_pkg::NUM_MST-1:0]                  mst_bready;
  logic                                            cfg_we;
  logic [axi_wr_pkg::CFG_ADDR_W-1:0]               cfg_addr;
  logic [axi_wr_pkg::CFG_DATA_W-1:0]               cfg_wdata;
  logic [axi_wr_pkg::CFG_DATA_W-1:0]               cfg_rdata;
  logic [axi_wr_pkg::MEM_IDX_W-1:0]                mem_rd_addr;
  logic [axi_wr_pkg::DATA_W-1:0]                   mem_rd_data;

  // Model of target memory and grant counters
  logic [axi_wr_pkg::DATA_W-1:0]  ref_mem [axi_wr_pkg::MEM_WORDS];
  bit                             written [axi_wr_pkg::MEM_WORDS];
  int                             exp_cnt [axi_wr_pkg::NUM_MST];
  int                             err_cnt = 0;
  int                             chk_fails;
  integer                         seed = 32'ha751;

  axi4_wr_subsys u_axi4_wr_subsys (.*);

  always #2 clk = ~clk;

  // 25 bursts of at most 4 beats plus read-back need well under 2000 cycles
  initial begin
    #20000;
    $display("Timeout: bursts or read-back did not complete in time");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic void mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
    err_cnt++;
    $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
  endfunction

  // --------------------
  // Config and read-back
  // --------------------
  task automatic cfg_write(input int addr, input logic [15:0] data);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr[axi_wr_pkg::CFG_ADDR_W-1:0];
    cfg_wdata <= data;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  // Read data is combinational, so sample mid-cycle
  task automatic check_reg(input string name, input int addr, input logic [15:0] exp);
    @(posedge clk);
    cfg_addr <= addr[axi_wr_pkg::CFG_ADDR_W-1:0];
    @(negedge clk);
    assert (cfg_rdata === exp) else mismatch(name, exp, cfg_rdata);
  endtask

  task automatic check_counters(input string name);
    for (int m = 0; m < axi_wr_pkg::NUM_MST; m++) begin
      check_reg($sformatf("%s, counter %0d", name, m), axi_wr_pkg::REG_GNT_BASE + m,
                exp_cnt[m][15:0]);
    end
  endtask

  // Registered read port, data one cycle after the address
  task automatic check_range(input string name, input int lo, input int hi);
    for (int w = lo; w <= hi; w++) begin
      if (written[w]) begin
        @(posedge clk);
        mem_rd_addr <= w[axi_wr_pkg::MEM_IDX_W-1:0];
        @(posedge clk);
        @(negedge clk);
        assert (mem_rd_data === ref_mem[w])
          else mismatch($sformatf("%s, word %0d", name, w), ref_mem[w], mem_rd_data);
      end
    end
  endtask

  // --------------------
  // Master burst
  // --------------------
  task automatic burst(input string name, input int m, input logic [2:0] id,
                       input int addr, input int len, input bit mixed);
    axi_wr_pkg::axi_aw_t  aw;
    axi_wr_pkg::axi_w_t   beat;
    axi_wr_pkg::axi_b_t   b;
    logic [1:0]           exp_resp;
    bit                   bad;
    int                   word;
    // Whole burst is rejected if its last word lies past the memory
    bad      = (addr / 4 + len) >= axi_wr_pkg::MEM_WORDS;
    exp_resp = bad ? axi_wr_pkg::RESP_SLVERR : axi_wr_pkg::RESP_OKAY;
    aw.id    = id;
    aw.addr  = addr[axi_wr_pkg::ADDR_W-1:0];
    aw.len   = len[7:0];
    @(posedge clk);
    mst_aw[m]      <= aw;
    mst_awvalid[m] <= 1'b1;
    for (int i = 0; i <= len; i++) begin
      beat.data = $random(seed);
      // Lane pattern changes every beat
      beat.strb = mixed ? {i[0], !i[0], i[1], !i[1]} : 4'hf;
      beat.last = (i == len);
      mst_w[m]      <= beat;
      mst_wvalid[m] <= 1'b1;
      // First beat waits alongside the address until the target opens W
      if (i == 0) begin
        do @(negedge clk); while (!mst_awready[m]);
        @(posedge clk);
        mst_awvalid[m] <= 1'b0;
      end
      do @(negedge clk); while (!mst_wready[m]);
      @(posedge clk);
      word = addr / 4 + i;
      if (!bad) begin
        for (int k = 0; k < axi_wr_pkg::STRB_W; k++) begin
          if (beat.strb[k]) begin
            ref_mem[word][8*k +: 8] = beat.data[8*k +: 8];
          end
        end
        written[word] = 1'b1;
      end
    end
    mst_wvalid[m] <= 1'b0;
    do @(negedge clk); while (!(mst_bvalid[m] && mst_bready[m]));
    b = mst_b[m];
    @(posedge clk);
    assert (b.id === id && b.resp === exp_resp)
      else mismatch($sformatf("%s response", name), {id, exp_resp}, b);
    exp_cnt[m]++;
  endtask

  initial begin
    rst_n       = 1'b0;
    mst_aw      = '0;
    mst_awvalid = '0;
    mst_w       = '0;
    mst_wvalid  = '0;
    mst_bready  = '1;
    cfg_we      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    mem_rd_addr = '0;
    for (int m = 0; m < axi_wr_pkg::NUM_MST; m++) begin
      exp_cnt[m] = 0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state
    @(negedge clk);
    assert ({mst_awready, mst_wready, mst_bvalid} === '0)
      else mismatch("reset outputs", 0, {mst_awready, mst_wready, mst_bvalid});
    check_reg("reset mask", axi_wr_pkg::REG_EN_MASK, 16'hf);
    check_counters("reset");

    // Single master, full then mixed strobes over words 0..3
    burst("single fill", 0, 3'd1, 0, 3, 1'b0);
    burst("single strobed", 0, 3'd2, 0, 3, 1'b1);
    check_range("single strobed", 0, 3);

    // All masters at once, round after round
    for (int r = 0; r < ROUNDS; r++) begin
      fork
        burst("all request m0", 0, {2'd0, r[0]}, 64 + 16 * r, 3, 1'b0);
        burst("all request m1", 1, {2'd1, r[0]}, 128 + 16 * r, 3, 1'b0);
        burst("all request m2", 2, {2'd2, r[0]}, 192 + 16 * r, 3, 1'b0);
        burst("all request m3", 3, {2'd3, r[0]}, 256 + 16 * r, 3, 1'b0);
      join
    end
    check_counters("all request");
    check_range("all request", 16, 79);

    // Master 2 masked while the others run
    cfg_write(axi_wr_pkg::REG_EN_MASK, 16'hb);
    fork
      burst("masked m2", 2, 3'd5, 512, 1, 1'b0);
    join_none
    fork
      burst("masked m0", 0, 3'd0, 528, 1, 1'b0);
      burst("masked m1", 1, 3'd2, 544, 1, 1'b0);
      burst("masked m3", 3, 3'd6, 560, 1, 1'b0);
    join
    check_counters("masked");
    cfg_write(axi_wr_pkg::REG_EN_MASK, 16'hf);
    wait fork;
    check_counters("re-enabled");
    check_range("masked", 128, 143);

    // Out of range bursts leave memory untouched
    burst("range fill", 3, 3'd7, 1008, 3, 1'b0);
    burst("range cross", 3, 3'd4, 1016, 3, 1'b0);
    burst("range start", 2, 3'd3, 1024, 0, 1'b0);
    check_range("range", 252, 255);
    check_range("range", 0, 3);

    // Master 1 stalls its response; nobody else may start
    @(posedge clk);
    mst_bready[1] <= 1'b0;
    fork
      burst("bready hold m1", 1, 3'd6, 768, 2, 1'b0);
      begin
        do @(negedge clk); while (!mst_bvalid[1]);
        repeat (20) begin
          assert (mst_awready === '0) else mismatch("bready hold awready", 0, mst_awready);
          @(negedge clk);
        end
        @(posedge clk);
        mst_bready[1] <= 1'b1;
      end
      begin
        do @(negedge clk); while (!mst_bvalid[1]);
        fork
          burst("bready hold m0", 0, 3'd1, 784, 1, 1'b0);
          burst("bready hold m2", 2, 3'd2, 800, 1, 1'b0);
          burst("bready hold m3", 3, 3'd3, 816, 1, 1'b0);
        join
      end
    join
    check_counters("bready hold");
    check_range("bready hold", 192, 207);

    chk_fails = u_axi4_wr_subsys.u_axi4_wr_subsys_chk.fail_cnt;
    $display("Summary: %0d check errors, %0d assertion failures", err_cnt, chk_fails);
    if (err_cnt == 0 && chk_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- wr_arb_cfg.sv
// Arbiter config registers: master enable mask and per-master grant counters
// Counters are read only and wrap at 16 bits
// Read data is combinational from the address

`default_nettype none

module wr_arb_cfg (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cfg_we,
  input  logic [axi_wr_pkg::CFG_ADDR_W-1:0]   cfg_addr,
  input  logic [axi_wr_pkg::CFG_DATA_W-1:0]   cfg_wdata,
  output logic [axi_wr_pkg::CFG_DATA_W-1:0]   cfg_rdata,
  input  logic                                gnt_stb,
  input  logic [axi_wr_pkg::MST_IDX_W-1:0]    gnt_idx,
  output logic [axi_wr_pkg::NUM_MST-1:0]      en_mask
);

  logic [axi_wr_pkg::CFG_DATA_W-1:0] gnt_cnt [axi_wr_pkg::NUM_MST];
  // Address relative to the first counter
  logic [axi_wr_pkg::CFG_ADDR_W-1:0] cnt_rel;

  assign cnt_rel = cfg_addr - axi_wr_pkg::REG_GNT_BASE;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_mask <= '1;
      for (int i = 0; i < axi_wr_pkg::NUM_MST; i++) begin
        gnt_cnt[i] <= '0;
      end
    end else begin
      if (cfg_we && cfg_addr == axi_wr_pkg::REG_EN_MASK) begin
        en_mask <= cfg_wdata[axi_wr_pkg::NUM_MST-1:0];
      end
      if (gnt_stb) begin
        gnt_cnt[gnt_idx] <= gnt_cnt[gnt_idx] + 1'b1;
      end
    end
  end

  // Unmapped indices read as zero
  always_comb begin
    cfg_rdata = '0;
    if (cfg_addr == axi_wr_pkg::REG_EN_MASK) begin
      cfg_rdata[axi_wr_pkg::NUM_MST-1:0] = en_mask;
    end else if (cnt_rel < axi_wr_pkg::NUM_MST) begin
      cfg_rdata = gnt_cnt[cnt_rel[axi_wr_pkg::MST_IDX_W-1:0]];
    end
  end

endmodule

`default_nettype wire
